/* rtl/trdb_cfg_pkg.sv */
// ============================================================
// trace debugger configuration package
// APB register map, configuration struct and status bits
// ============================================================

`default_nettype none

package trdb_cfg_pkg;

    // decoded part of the APB address
    localparam int APB_ADDR_W = 4;

    // register byte offsets
    localparam logic [APB_ADDR_W-1:0] REG_CTRL   = 4'h0;
    localparam logic [APB_ADDR_W-1:0] REG_LOWER  = 4'h4;
    localparam logic [APB_ADDR_W-1:0] REG_UPPER  = 4'h8;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS = 4'hC;

    // trace enable in REG_CTRL
    localparam int CTRL_EN_BIT = 0;
    // sticky overflow in REG_STATUS, write 1 to clear
    localparam int STATUS_OVF_BIT = 0;

    // configuration seen by the address filter
    typedef struct packed {
        logic        enable;
        logic [31:0] lower;
        logic [31:0] upper;
    } trdb_cfg_t;

endpackage

`default_nettype wire

/* rtl/trdb_trace_pkg.sv */
// ============================================================
// trace debugger trace package
// retire record, instruction classes, packet format and sizing
// ============================================================

`default_nettype none

package trdb_trace_pkg;

    localparam int XLEN           = 32;
    localparam int CAUSE_LEN      = 5;
    localparam int BRANCH_MAP_LEN = 16;
    localparam int BRANCH_CNT_W   = 5;
    localparam int MAP_IDX_W      = $clog2(BRANCH_MAP_LEN);
    localparam int FIFO_DEPTH     = 4;
    localparam int FIFO_PTR_W     = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W     = FIFO_PTR_W + 1;

    localparam logic [XLEN-1:0] MRET_INSN = 32'h3020_0073;

    // major opcodes and compressed quadrants used by the decoder
    typedef enum logic [6:0] {
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [1:0] {
        COP_Q1 = 2'b01,
        COP_Q2 = 2'b10
    } c_quadrant_e;

    typedef struct packed {
        logic                 valid;
        logic                 exception;
        logic [CAUSE_LEN-1:0] cause;
        logic                 compressed;
        logic [XLEN-1:0]      addr;
        logic [XLEN-1:0]      instr;
    } retire_t;

    typedef enum logic [1:0] {
        INSN_OTHER,
        INSN_BRANCH,
        INSN_JUMP
    } insn_class_e;

    typedef struct packed {
        retire_t     rec;
        insn_class_e cls;
    } classified_t;

    typedef struct packed {
        logic qualified;
        logic first;
    } qual_t;

    typedef enum logic [1:0] {
        PKT_START,
        PKT_ADDR,
        PKT_EXCEPTION,
        PKT_BRANCH_FULL
    } trace_fmt_e;

    typedef struct packed {
        trace_fmt_e                fmt;
        logic [BRANCH_CNT_W-1:0]   branch_cnt;
        logic [BRANCH_MAP_LEN-1:0] branch_map;
        logic [XLEN-1:0]           addr;
        logic [CAUSE_LEN-1:0]      cause;
    } trace_packet_t;

endpackage

`default_nettype wire

/* rtl/trdb_apb_regs.sv */
// ============================================================
// trace debugger APB register block
// control, address range and sticky overflow status
// zero wait state slave
// ============================================================

`timescale 1ns/1ps
`default_nettype none

module trdb_apb_regs (
    input  wire logic                               clk_gated,
    input  wire logic                               rst_ni,
    input  wire logic [trdb_cfg_pkg::APB_ADDR_W-1:0] paddr_i,
    input  wire logic [31:0]                        pwdata_i,
    input  wire logic                               pwrite_i,
    input  wire logic                               psel_i,
    input  wire logic                               penable_i,
    output logic [31:0]                             prdata_o,
    output logic                                    pready_o,
    output logic                                    pslverr_o,
    input  wire logic                               overflow_i,
    output trdb_cfg_pkg::trdb_cfg_t                 cfg_o
);

    logic        access;
    logic        aligned;
    logic        wr_en;
    logic        enable_q;
    logic [31:0] lower_q;
    logic [31:0] upper_q;
    logic        ovf_q;
    logic        ovf_clr;

    assign access  = psel_i && penable_i;
    assign aligned = (paddr_i[1:0] == 2'b00);
    assign wr_en   = access && pwrite_i && aligned;
    assign ovf_clr = wr_en && (paddr_i == trdb_cfg_pkg::REG_STATUS) &&
                     pwdata_i[trdb_cfg_pkg::STATUS_OVF_BIT];

    assign pready_o  = 1'b1;
    assign pslverr_o = access && !aligned;

    always_ff @(posedge clk_gated or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q <= 1'b0;
            lower_q  <= '0;
            upper_q  <= '0;
        end else if (wr_en) begin
            case (paddr_i)
                trdb_cfg_pkg::REG_CTRL:  enable_q <= pwdata_i[trdb_cfg_pkg::CTRL_EN_BIT];
                trdb_cfg_pkg::REG_LOWER: lower_q  <= pwdata_i;
                trdb_cfg_pkg::REG_UPPER: upper_q  <= pwdata_i;
                default: ;
            endcase
        end
    end

    // a new overflow beats a clear in the same cycle
    always_ff @(posedge clk_gated or negedge rst_ni) begin
        if (!rst_ni) begin
            ovf_q <= 1'b0;
        end else if (overflow_i) begin
            ovf_q <= 1'b1;
        end else if (ovf_clr) begin
            ovf_q <= 1'b0;
        end
    end

    always_comb begin
        prdata_o = '0;
        if (access && !pwrite_i && aligned) begin
            case (paddr_i)
                trdb_cfg_pkg::REG_CTRL:   prdata_o[trdb_cfg_pkg::CTRL_EN_BIT] = enable_q;
                trdb_cfg_pkg::REG_LOWER:  prdata_o = lower_q;
                trdb_cfg_pkg::REG_UPPER:  prdata_o = upper_q;
                trdb_cfg_pkg::REG_STATUS: prdata_o[trdb_cfg_pkg::STATUS_OVF_BIT] = ovf_q;
                default: ;
            endcase
        end
    end

    assign cfg_o = '{enable: enable_q, lower: lower_q, upper: upper_q};

endmodule

`default_nettype wire

/* rtl/trdb_insn_classify.sv */
// ============================================================
// trace debugger instruction classifier
// registers the retire record with its branch or jump class
// ============================================================

`timescale 1ns/1ps
`default_nettype none

module trdb_insn_classify (
    input  wire logic                        clk_gated,
    input  wire logic                        rst_ni,
    input  wire trdb_trace_pkg::retire_t     retire_i,
    output trdb_trace_pkg::classified_t      insn_o
);

    logic [trdb_trace_pkg::XLEN-1:0] instr;
    trdb_trace_pkg::insn_class_e     cls;

    assign instr = retire_i.instr;

    always_comb begin
        cls = trdb_trace_pkg::INSN_OTHER;
        if (retire_i.compressed) begin
            // c.beqz and c.bnez
            if (instr[1:0] == trdb_trace_pkg::COP_Q1 && instr[15:14] == 2'b11) begin
                cls = trdb_trace_pkg::INSN_BRANCH;
            // c.jr and c.jalr need rs1 != 0 and rs2 == 0
            end else if (instr[1:0] == trdb_trace_pkg::COP_Q2 && instr[15:13] == 3'b100 &&
                         instr[11:7] != 5'd0 && instr[6:2] == 5'd0) begin
                cls = trdb_trace_pkg::INSN_JUMP;
            end
        end else begin
            if (instr[6:0] == trdb_trace_pkg::OPC_BRANCH) begin
                cls = trdb_trace_pkg::INSN_BRANCH;
            end else if (instr[6:0] == trdb_trace_pkg::OPC_JALR ||
                         instr == trdb_trace_pkg::MRET_INSN) begin
                cls = trdb_trace_pkg::INSN_JUMP;
            end
        end
    end

    always_ff @(posedge clk_gated or negedge rst_ni) begin
        if (!rst_ni) begin
            insn_o <= '0;
        end else begin
            insn_o <= '{rec: retire_i, cls: cls};
        end
    end

endmodule

`default_nettype wire

/* rtl/trdb_addr_filter.sv */
// ============================================================
// trace debugger address filter
// range qualification and first qualified detection
// ============================================================

`timescale 1ns/1ps
`default_nettype none

module trdb_addr_filter (
    input  wire logic                        clk_gated,
    input  wire logic                        rst_ni,
    input  wire trdb_trace_pkg::retire_t     retire_i,
    input  wire trdb_cfg_pkg::trdb_cfg_t     cfg_i,
    output trdb_trace_pkg::qual_t            qual_o
);

    logic in_range;
    logic hit;
    logic prev_qual_q;

    // bounds are inclusive
    assign in_range = cfg_i.enable && (retire_i.addr >= cfg_i.lower) &&
                      (retire_i.addr <= cfg_i.upper);
    assign hit = retire_i.valid && in_range;

    always_ff @(posedge clk_gated or negedge rst_ni) begin
        if (!rst_ni) begin
            qual_o      <= '0;
            prev_qual_q <= 1'b0;
        end else begin
            qual_o <= '{qualified: hit, first: hit && !prev_qual_q};
            // only valid retirements update the history
            if (retire_i.valid) begin
                prev_qual_q <= in_range;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/trdb_packet_gen.sv */
// ============================================================
// trace debugger packet generator
// holds the pending instruction, keeps the branch map and
// decides which packet to emit when the next one arrives
// ============================================================

`timescale 1ns/1ps
`default_nettype none

module trdb_packet_gen (
    input  wire logic                        clk_gated,
    input  wire logic                        rst_ni,
    input  wire trdb_trace_pkg::classified_t insn_i,
    input  wire trdb_trace_pkg::qual_t       qual_i,
    output trdb_trace_pkg::trace_packet_t    packet_o,
    output logic                             push_o
);

    localparam int MAP_LEN = trdb_trace_pkg::BRANCH_MAP_LEN;
    localparam int CNT_W   = trdb_trace_pkg::BRANCH_CNT_W;

    logic                            next_valid;
    logic                            eval;
    logic                            taken;
    logic [trdb_trace_pkg::XLEN-1:0] next_addr;
    logic [trdb_trace_pkg::XLEN-1:0] seq_addr;

    logic                            pend_valid_q;
    logic                            pend_first_q;
    trdb_trace_pkg::classified_t     pend_q;

    logic [MAP_LEN-1:0]              map_q;
    logic [MAP_LEN-1:0]              map_d;
    logic [CNT_W-1:0]                cnt_q;
    logic [CNT_W-1:0]                cnt_d;

    assign next_valid = insn_i.rec.valid && qual_i.qualified;
    assign eval       = next_valid && pend_valid_q;
    assign next_addr  = insn_i.rec.addr;

    // fall through address of the pending instruction
    assign seq_addr = pend_q.rec.addr + (pend_q.rec.compressed ? 32'd2 : 32'd4);
    assign taken    = (next_addr != seq_addr);

    always_comb begin
        packet_o = '0;
        push_o   = 1'b0;
        map_d    = map_q;
        cnt_d    = cnt_q;
        if (eval) begin
            packet_o.branch_map = map_q;
            packet_o.branch_cnt = cnt_q;
            if (pend_q.rec.exception) begin
                push_o         = 1'b1;
                packet_o.fmt   = trdb_trace_pkg::PKT_EXCEPTION;
                packet_o.addr  = pend_q.rec.addr;
                packet_o.cause = pend_q.rec.cause;
            end else if (pend_first_q) begin
                push_o        = 1'b1;
                packet_o.fmt  = trdb_trace_pkg::PKT_START;
                packet_o.addr = pend_q.rec.addr;
            end else if (pend_q.cls == trdb_trace_pkg::INSN_JUMP) begin
                push_o        = 1'b1;
                packet_o.fmt  = trdb_trace_pkg::PKT_ADDR;
                packet_o.addr = next_addr;
            end
            if (push_o) begin
                map_d = '0;
                cnt_d = '0;
            end
            if (pend_q.cls == trdb_trace_pkg::INSN_BRANCH) begin
                map_d[cnt_d[trdb_trace_pkg::MAP_IDX_W-1:0]] = taken;
                cnt_d = cnt_d + 1'b1;
                // the map was cleared above if a packet went out, so no clash
                if (cnt_d == CNT_W'(MAP_LEN)) begin
                    push_o   = 1'b1;
                    packet_o = '{fmt: trdb_trace_pkg::PKT_BRANCH_FULL, branch_cnt: cnt_d,
                                 branch_map: map_d, addr: '0, cause: '0};
                    map_d    = '0;
                    cnt_d    = '0;
                end
            end
        end
    end

    always_ff @(posedge clk_gated or negedge rst_ni) begin
        if (!rst_ni) begin
            pend_valid_q <= 1'b0;
            pend_first_q <= 1'b0;
            map_q        <= '0;
            cnt_q        <= '0;
        end else begin
            map_q <= map_d;
            cnt_q <= cnt_d;
            if (next_valid) begin
                pend_valid_q <= 1'b1;
                pend_first_q <= qual_i.first;
            end
        end
    end

    always_ff @(posedge clk_gated) begin
        if (next_valid) begin
            pend_q <= insn_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/trdb_packet_fifo.sv */
// ============================================================
// trace debugger packet FIFO
// circular buffer toward the consumer, drops on overflow
// ============================================================

`timescale 1ns/1ps
`default_nettype none

module trdb_packet_fifo (
    input  wire logic                          clk_gated,
    input  wire logic                          rst_ni,
    input  wire trdb_trace_pkg::trace_packet_t packet_i,
    input  wire logic                          push_i,
    output trdb_trace_pkg::trace_packet_t      packet_o,
    output logic                               valid_o,
    input  wire logic                          ready_i,
    output logic                               overflow_o
);

    localparam int DEPTH = trdb_trace_pkg::FIFO_DEPTH;
    localparam int PTR_W = trdb_trace_pkg::FIFO_PTR_W;
    localparam int CNT_W = trdb_trace_pkg::FIFO_CNT_W;

    trdb_trace_pkg::trace_packet_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             pop;
    logic             wr;

    assign full       = (count_q == CNT_W'(DEPTH));
    assign valid_o    = (count_q != '0);
    assign pop        = valid_o && ready_i;
    // a pop frees the slot in the same cycle
    assign wr         = push_i && (!full || pop);
    assign overflow_o = push_i && full && !pop;
    assign packet_o   = mem[rd_ptr_q];

    always_ff @(posedge clk_gated or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (wr && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !wr) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_gated) begin
        if (wr) begin
            mem[wr_ptr_q] <= packet_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/trace_debugger.sv */
// ============================================================
// RISC-V instruction trace encoder top level
// classifies and filters retirements in parallel, then forms
// packets into a FIFO drained by valid/ready
// ============================================================

`timescale 1ns/1ps
`default_nettype none

module trace_debugger (
    input  wire logic                               clk_gated,
    input  wire logic                               rst_ni,
    input  wire trdb_trace_pkg::retire_t            retire_i,
    input  wire logic [trdb_cfg_pkg::APB_ADDR_W-1:0] paddr_i,
    input  wire logic [31:0]                        pwdata_i,
    input  wire logic                               pwrite_i,
    input  wire logic                               psel_i,
    input  wire logic                               penable_i,
    output logic [31:0]                             prdata_o,
    output logic                                    pready_o,
    output logic                                    pslverr_o,
    output trdb_trace_pkg::trace_packet_t           packet_o,
    output logic                                    packet_valid_o,
    input  wire logic                               packet_ready_i
);

    trdb_cfg_pkg::trdb_cfg_t       cfg;
    trdb_trace_pkg::classified_t   insn;
    trdb_trace_pkg::qual_t         qual;
    trdb_trace_pkg::trace_packet_t gen_packet;
    logic                          push;
    logic                          overflow;

    trdb_apb_regs i_apb_regs (
        .clk_gated  (clk_gated),
        .rst_ni     (rst_ni),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .pwrite_i   (pwrite_i),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .overflow_i (overflow),
        .cfg_o      (cfg)
    );

    // classify and filter run side by side on the same retirement
    trdb_insn_classify i_insn_classify (
        .clk_gated (clk_gated),
        .rst_ni    (rst_ni),
        .retire_i  (retire_i),
        .insn_o    (insn)
    );

    trdb_addr_filter i_addr_filter (
        .clk_gated (clk_gated),
        .rst_ni    (rst_ni),
        .retire_i  (retire_i),
        .cfg_i     (cfg),
        .qual_o    (qual)
    );

    trdb_packet_gen i_packet_gen (
        .clk_gated (clk_gated),
        .rst_ni    (rst_ni),
        .insn_i    (insn),
        .qual_i    (qual),
        .packet_o  (gen_packet),
        .push_o    (push)
    );

    trdb_packet_fifo i_packet_fifo (
        .clk_gated  (clk_gated),
        .rst_ni     (rst_ni),
        .packet_i   (gen_packet),
        .push_i     (push),
        .packet_o   (packet_o),
        .valid_o    (packet_valid_o),
        .ready_i    (packet_ready_i),
        .overflow_o (overflow)
    );

endmodule

`default_nettype wire

/* test/tb_trace_debugger.sv */
// ============================================================
// trace encoder testbench
// APB register access, retire stimulus table and expected
// packet table with a packet monitor and overflow checks
// ============================================================

`timescale 1ns/1ps
`default_nettype none

module tb_trace_debugger;

    localparam logic [31:0] INSN_NOP   = 32'h0000_0013;
    localparam logic [31:0] INSN_BEQ   = 32'h0000_0063;
    localparam logic [31:0] INSN_JALR  = 32'h0000_8067;
    localparam logic [31:0] INSN_CBEQZ = 32'h0000_C001;
    localparam logic [31:0] INSN_CJR   = 32'h0000_8082;
    localparam logic [31:0] INSN_MRET  = 32'h3020_0073;

    logic                                  clk_gated;
    logic                                  rst_ni;
    trdb_trace_pkg::retire_t               retire_i;
    logic [trdb_cfg_pkg::APB_ADDR_W-1:0]   paddr_i;
    logic [31:0]                           pwdata_i;
    logic                                  pwrite_i;
    logic                                  psel_i;
    logic                                  penable_i;
    logic [31:0]                           prdata_o;
    logic                                  pready_o;
    logic                                  pslverr_o;
    trdb_trace_pkg::trace_packet_t         packet_o;
    logic                                  packet_valid_o;
    logic                                  packet_ready_i;

    trdb_trace_pkg::retire_t       stim_tab [0:63];
    trdb_trace_pkg::trace_packet_t exp_tab [0:15];
    int n_stim = 0;
    int n_exp = 0;
    int rcv_count = 0;
    int ovf_row = 0;
    int ovf_exp = 0;
    int err_packet = 0;
    int err_word = 0;
    int err_flag = 0;
    int err_other = 0;
    // 0 random ready, 1 held low, 2 held high
    int ready_mode = 0;
    logic [31:0] lcg_state = 32'd69;

    trace_debugger dut0 (
        .clk_gated      (clk_gated),
        .rst_ni         (rst_ni),
        .retire_i       (retire_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .pwrite_i       (pwrite_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .prdata_o       (prdata_o),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o),
        .packet_o       (packet_o),
        .packet_valid_o (packet_valid_o),
        .packet_ready_i (packet_ready_i)
    );

    initial begin
        clk_gated = 1'b0;
    end

    always #4 clk_gated = ~clk_gated;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        lcg_next = s * 32'd1103515245 + 32'd12345;
    endfunction

    // consumer back-pressure
    always @(posedge clk_gated) begin
        if (ready_mode == 0) begin
            lcg_state = lcg_next(lcg_state);
            packet_ready_i <= (lcg_state[17:16] != 2'b00);
        end else if (ready_mode == 1) begin
            packet_ready_i <= 1'b0;
        end else begin
            packet_ready_i <= 1'b1;
        end
    end

    task automatic check_packet(input trdb_trace_pkg::trace_packet_t got,
                                input trdb_trace_pkg::trace_packet_t exp);
        if (got !== exp) begin
            err_packet++;
            $display("FAILED t=%0t packet_o got %h exp %h", $time, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            err_word++;
            $display("FAILED t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_flag++;
            $display("FAILED t=%0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    // transfer happens at the next rising edge when both are high here
    always @(negedge clk_gated) begin
        if (rst_ni && packet_valid_o && packet_ready_i) begin
            if (rcv_count < n_exp) begin
                check_packet(packet_o, exp_tab[rcv_count]);
            end else begin
                err_other++;
                $display("unexpected extra packet %h at t=%0t", packet_o, $time);
            end
            rcv_count++;
        end
    end

    task automatic apb_access(input logic [3:0] addr, input logic [31:0] data,
                              input logic write, output logic [31:0] rdata,
                              output logic err);
        @(posedge clk_gated);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= write;
        paddr_i   <= addr;
        pwdata_i  <= data;
        @(posedge clk_gated);
        penable_i <= 1'b1;
        // zero wait states, the access completes at the next edge
        @(negedge clk_gated);
        check_flag("pready_o", pready_o, 1'b1);
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk_gated);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] unused;
        logic        err;
        apb_access(addr, data, 1'b1, unused, err);
        check_flag("pslverr_o", err, exp_err);
    endtask

    task automatic read_reg(input logic [3:0] addr, input logic [31:0] exp,
                            input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(addr, 32'h0, 1'b0, rdata, err);
        check_word("prdata_o", rdata, exp);
        check_flag("pslverr_o", err, exp_err);
    endtask

    task automatic add_row(input logic [31:0] addr, input logic [31:0] instr,
                           input logic compressed, input logic [4:0] cause,
                           input logic exc);
        trdb_trace_pkg::retire_t r;
        r            = '0;
        r.valid      = 1'b1;
        r.exception  = exc;
        r.cause      = cause;
        r.compressed = compressed;
        r.addr       = addr;
        r.instr      = instr;
        stim_tab[n_stim] = r;
        n_stim++;
    endtask

    task automatic add_bubble();
        stim_tab[n_stim] = '0;
        n_stim++;
    endtask

    task automatic add_expected(input trdb_trace_pkg::trace_fmt_e fmt, input logic [4:0] cnt,
                                input logic [15:0] map, input logic [31:0] addr,
                                input logic [4:0] cause);
        trdb_trace_pkg::trace_packet_t p;
        p            = '0;
        p.fmt        = fmt;
        p.branch_cnt = cnt;
        p.branch_map = map;
        p.addr       = addr;
        p.cause      = cause;
        exp_tab[n_exp] = p;
        n_exp++;
    endtask

    task automatic build_tables();
        logic [31:0] a;
        // start and jump
        add_row(32'h1000, INSN_NOP, 1'b0, 5'd0, 1'b0);
        add_row(32'h1004, INSN_NOP, 1'b0, 5'd0, 1'b0);
        add_row(32'h1008, INSN_JALR, 1'b0, 5'd0, 1'b0);
        add_bubble();
        add_row(32'h1100, INSN_NOP, 1'b0, 5'd0, 1'b0);
        add_expected(trdb_trace_pkg::PKT_START, 5'd0, 16'h0, 32'h1000, 5'd0);
        add_expected(trdb_trace_pkg::PKT_ADDR, 5'd0, 16'h0, 32'h1100, 5'd0);
        // taken, not taken (compressed), taken, then a jalr
        add_row(32'h1104, INSN_BEQ, 1'b0, 5'd0, 1'b0);
        add_row(32'h1200, INSN_CBEQZ, 1'b1, 5'd0, 1'b0);
        add_row(32'h1202, INSN_BEQ, 1'b0, 5'd0, 1'b0);
        add_row(32'h1300, INSN_JALR, 1'b0, 5'd0, 1'b0);
        add_row(32'h1400, INSN_NOP, 1'b0, 5'd0, 1'b0);
        add_expected(trdb_trace_pkg::PKT_ADDR, 5'd3, 16'h0005, 32'h1400, 5'd0);
        // sixteen branches, every fourth one taken
        a = 32'h1404;
        for (int k = 0; k < 16; k++) begin
            add_row(a, INSN_BEQ, 1'b0, 5'd0, 1'b0);
            a = (k % 4 == 3) ? a + 32'd16 : a + 32'd4;
        end
        add_expected(trdb_trace_pkg::PKT_BRANCH_FULL, 5'd16, 16'h8888, 32'h0, 5'd0);
        // jalr at 0x1474 leaves the range, target comes back at 0x1800
        add_row(a, INSN_JALR, 1'b0, 5'd0, 1'b0);
        add_row(32'h3000, INSN_NOP, 1'b0, 5'd0, 1'b0);
        add_row(32'h3004, INSN_JALR, 1'b0, 5'd0, 1'b0);
        add_bubble();
        add_row(32'h1800, INSN_NOP, 1'b0, 5'd0, 1'b0);
        add_row(32'h1804, INSN_NOP, 1'b0, 5'd0, 1'b0);
        add_expected(trdb_trace_pkg::PKT_ADDR, 5'd0, 16'h0, 32'h1800, 5'd0);
        add_expected(trdb_trace_pkg::PKT_START, 5'd0, 16'h0, 32'h1800, 5'd0);
        // exception with cause 11, handler at 0x1900
        add_row(32'h1808, INSN_NOP, 1'b0, 5'd11, 1'b1);
        add_row(32'h1900, INSN_NOP, 1'b0, 5'd0, 1'b0);
        add_expected(trdb_trace_pkg::PKT_EXCEPTION, 5'd0, 16'h0, 32'h1808, 5'd11);
        // overflow chain, seven jumps give six packets
        ovf_row = n_stim;
        ovf_exp = n_exp;
        for (int k = 0; k < 7; k++) begin
            a = 32'h1A00 + 32'h10 * k;
            case (k % 3)
                0: add_row(a, INSN_JALR, 1'b0, 5'd0, 1'b0);
                1: add_row(a, INSN_CJR, 1'b1, 5'd0, 1'b0);
                default: add_row(a, INSN_MRET, 1'b0, 5'd0, 1'b0);
            endcase
        end
        for (int k = 1; k <= trdb_trace_pkg::FIFO_DEPTH; k++) begin
            add_expected(trdb_trace_pkg::PKT_ADDR, 5'd0, 16'h0, 32'h1A00 + 32'h10 * k, 5'd0);
        end
    endtask

    task automatic apply_rows(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            @(posedge clk_gated);
            retire_i <= stim_tab[i];
        end
        @(posedge clk_gated);
        retire_i <= '0;
    endtask

    task automatic wait_packets(input int n);
        int cycles;
        cycles = 0;
        while (rcv_count < n && cycles < 400) begin
            @(posedge clk_gated);
            cycles++;
        end
        if (rcv_count < n) begin
            err_other++;
            $display("timed out waiting for packets, got %0d of %0d", rcv_count, n);
        end
    endtask

    initial begin
        #100000;
        $display("simulation ran too long and was stopped");
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] rdata;
        logic        err;
        int          tries;
        rst_ni         = 1'b0;
        retire_i       = '0;
        paddr_i        = '0;
        pwdata_i       = '0;
        pwrite_i       = 1'b0;
        psel_i         = 1'b0;
        penable_i      = 1'b0;
        packet_ready_i = 1'b0;
        build_tables();
        repeat (5) @(posedge clk_gated);
        rst_ni <= 1'b1;

        // register access
        read_reg(trdb_cfg_pkg::REG_STATUS, 32'h0, 1'b0);
        write_reg(trdb_cfg_pkg::REG_LOWER, 32'h0000_1000, 1'b0);
        write_reg(trdb_cfg_pkg::REG_UPPER, 32'h0000_1FFF, 1'b0);
        read_reg(trdb_cfg_pkg::REG_LOWER, 32'h0000_1000, 1'b0);
        read_reg(trdb_cfg_pkg::REG_UPPER, 32'h0000_1FFF, 1'b0);
        write_reg(trdb_cfg_pkg::REG_CTRL, 32'h1, 1'b0);
        read_reg(trdb_cfg_pkg::REG_CTRL, 32'h1, 1'b0);
        write_reg(4'h6, 32'hDEAD_BEEF, 1'b1);
        read_reg(4'h2, 32'h0, 1'b1);
        read_reg(trdb_cfg_pkg::REG_LOWER, 32'h0000_1000, 1'b0);
        // setup phase only, must not write or flag an error
        @(posedge clk_gated);
        psel_i   <= 1'b1;
        pwrite_i <= 1'b1;
        paddr_i  <= trdb_cfg_pkg::REG_CTRL;
        pwdata_i <= 32'h0;
        @(posedge clk_gated);
        paddr_i  <= 4'h2;
        @(negedge clk_gated);
        check_flag("pslverr_o", pslverr_o, 1'b0);
        @(posedge clk_gated);
        psel_i   <= 1'b0;
        pwrite_i <= 1'b0;
        read_reg(trdb_cfg_pkg::REG_CTRL, 32'h1, 1'b0);

        // trace with random back-pressure
        apply_rows(0, ovf_row - 1);
        wait_packets(ovf_exp);
        read_reg(trdb_cfg_pkg::REG_STATUS, 32'h0, 1'b0);

        // overflow with the consumer stalled
        @(negedge clk_gated);
        ready_mode = 1;
        apply_rows(ovf_row, n_stim - 1);
        tries = 0;
        rdata = '0;
        while (!rdata[0] && tries < 20) begin
            apb_access(trdb_cfg_pkg::REG_STATUS, 32'h0, 1'b0, rdata, err);
            tries++;
        end
        check_flag("overflow flag", rdata[0], 1'b1);
        @(negedge clk_gated);
        ready_mode = 2;
        wait_packets(n_exp);
        @(posedge clk_gated);
        @(negedge clk_gated);
        check_flag("packet_valid_o", packet_valid_o, 1'b0);
        write_reg(trdb_cfg_pkg::REG_STATUS, 32'h1, 1'b0);
        read_reg(trdb_cfg_pkg::REG_STATUS, 32'h0, 1'b0);

        $display("errors: packet %0d, word %0d, flag %0d, other %0d",
                 err_packet, err_word, err_flag, err_other);
        if (err_packet + err_word + err_flag + err_other == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* trace_debugger.f */
rtl/trdb_cfg_pkg.sv
rtl/trdb_trace_pkg.sv
rtl/trdb_apb_regs.sv
rtl/trdb_insn_classify.sv
rtl/trdb_addr_filter.sv
rtl/trdb_packet_gen.sv
rtl/trdb_packet_fifo.sv
rtl/trace_debugger.sv
test/tb_trace_debugger.sv
